// ==== wtb_loader_top.f ====
+incdir+rtl
rtl/wtb_pkg.sv
rtl/wtb_ifs.sv
rtl/wtb_loader_fsm.sv
rtl/wtb_key_fetch.sv
rtl/wtb_interp.sv
rtl/wtb_credit_out.sv
rtl/wtb_loader_top.sv
sim/wtb_clk_gen.sv
sim/wtb_loader_properties.sv
sim/wtb_loader_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := wtb_loader_tb
RTL_TOP    := wtb_loader_top
FILELIST   := wtb_loader_top.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/wtb_loader_tb.sv ====
`include "wtb_config.svh"

module wtb_loader_tb;

    localparam int ram_size = `WTB_RAM_SIZE;
    localparam int num_loads = 6;
    localparam int timeout_cycles = num_loads * (`WTB_RAM_SIZE * 10 + 40);

    logic                   clk;
    logic                   rst = 1'b1;
    logic                   wtb_load = 1'b0;
    logic                   key_we = 1'b0;
    logic [`WTB_KEY_AW-1:0] key_addr = '0;
    logic [`WTB_POS_W-1:0]  key_pos = '0;
    logic [`WTB_DATA_W-1:0] key_val = '0;
    logic                   credit_return = 1'b0;
    logic                   out_valid;
    logic [`WTB_ADDR_W-1:0] out_addr;
    logic [`WTB_DATA_W-1:0] out_data;
    logic                   idle;
    logic                   done;

    int seed = 32'hf7ce;
    int errors = 0;
    int cycle_count = 0;
    int next_addr = 0;
    int done_count = 0;
    int outstanding = 0;
    int credit_due [$];

    // Key points as the host wrote them, and the table they must give
    int kp [0:`WTB_KEY_DEPTH-1];
    int kv [0:`WTB_KEY_DEPTH-1];
    int exp_tab [0:ram_size-1];
    int got_tab [0:ram_size-1];

    wtb_clk_gen clk_gen0 (.clk(clk));

    wtb_loader_top dut0 (
        .clk(clk), .rst(rst), .wtb_load(wtb_load), .key_we(key_we), .key_addr(key_addr),
        .key_pos(key_pos), .key_val(key_val), .credit_return(credit_return),
        .out_valid(out_valid), .out_addr(out_addr), .out_data(out_data),
        .idle(idle), .done(done)
    );

    bind wtb_loader_top wtb_loader_properties props0 (
        .clk(clk), .rst(rst), .out_valid(out_valid), .credit_return(credit_return),
        .idle(idle), .done(done)
    );

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h",
                                     name, expected, actual));
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    // Linear interpolation truncated toward zero, plus offset, clamped to a byte
    function automatic int interp_word(input int pl, input int vl, input int pr, input int vr,
                                       input int a, input int off);
        int w;
        w = vl + ((vr - vl) * (a - pl)) / (pr - pl) + off;
        if (w < 0) begin
            w = 0;
        end else if (w > 255) begin
            w = 255;
        end
        return w;
    endfunction

    task automatic make_keys(input int nseg, input int off);
        int i;
        int lo;
        int hi;
        int step_max;
        kp[0] = 0;
        kv[0] = off & 255;
        kp[1] = 0;
        kv[1] = rand_below(256);
        // A nonzero offset pushes the first key past the byte range
        if (off > 0) begin
            kv[1] = 255;
        end else if (off < 0) begin
            kv[1] = 0;
        end
        for (i = 2; i <= nseg; i++) begin
            lo = kp[i - 1] + 1;
            hi = ram_size - 1 - (nseg + 1 - i);
            step_max = hi - lo + 1;
            if (step_max > 120 / nseg) begin
                step_max = 120 / nseg;
            end
            kp[i] = lo + rand_below(step_max);
            kv[i] = rand_below(256);
        end
        kp[nseg + 1] = ram_size - 1;
        kv[nseg + 1] = rand_below(256);
    endtask

    task automatic build_expected(input int nseg);
        int k;
        int a;
        int off;
        off = (kv[0] >= 128) ? kv[0] - 256 : kv[0];
        for (k = 1; k <= nseg; k++) begin
            for (a = kp[k]; a < kp[k + 1]; a++) begin
                exp_tab[a] = interp_word(kp[k], kv[k], kp[k + 1], kv[k + 1], a, off);
            end
        end
        // The last right key also gives the final entry
        exp_tab[ram_size - 1] = interp_word(kp[nseg], kv[nseg], kp[nseg + 1], kv[nseg + 1],
                                            ram_size - 1, off);
    endtask

    task automatic run_load(input int nseg, input int off, input bit extra_load,
                            input bit garbage);
        int i;
        int g;
        make_keys(nseg, off);
        for (i = 0; i <= nseg + 1; i++) begin
            @(posedge clk);
            key_we   <= 1'b1;
            key_addr <= i[`WTB_KEY_AW-1:0];
            key_pos  <= kp[i][`WTB_POS_W-1:0];
            key_val  <= kv[i][`WTB_DATA_W-1:0];
        end
        @(posedge clk);
        key_we <= 1'b0;
        build_expected(nseg);
        for (i = 0; i < ram_size; i++) begin
            got_tab[i] = -1;
        end
        next_addr  = 0;
        done_count = 0;
        @(posedge clk);
        wtb_load <= 1'b1;
        @(posedge clk);
        wtb_load <= 1'b0;
        // The FSM is busy for far longer than these writes last
        if (garbage) begin
            for (i = 0; i < 20; i++) begin
                g = rand_below(1 << 20);
                key_we   <= 1'b1;
                key_addr <= g[3:0];
                key_pos  <= g[11:4];
                key_val  <= g[19:12];
                @(posedge clk);
            end
            key_we <= 1'b0;
        end
        if (extra_load) begin
            repeat (10) @(posedge clk);
            wtb_load <= 1'b1;
            @(posedge clk);
            wtb_load <= 1'b0;
        end
        while (done_count == 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_value("idle", 1, int'(idle));
        repeat (20) @(posedge clk);
        check_value("done_count", 1, done_count);
        check_value("word_count", ram_size, next_addr);
        check_value("idle", 1, int'(idle));
        for (i = 0; i < ram_size; i++) begin
            check_value($sformatf("out_data[%0d]", i), exp_tab[i], got_tab[i]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("Timeout: the loads did not finish in %0d cycles",
                                     timeout_cycles));
        end
    end

    // Consumer stores each word and returns its credit after 0 to 7 cycles
    always @(posedge clk) begin
        if (rst) begin
            credit_return <= 1'b0;
            outstanding = 0;
            credit_due.delete();
        end else begin
            if (credit_return) begin
                outstanding = outstanding - 1;
            end
            if (out_valid) begin
                outstanding = outstanding + 1;
                check_value("outstanding_ok", 1, int'(outstanding <= `WTB_CREDITS));
                check_value("out_addr", next_addr, int'(out_addr));
                got_tab[out_addr] = int'(out_data);
                next_addr = next_addr + 1;
                credit_due.push_back(cycle_count + rand_below(8));
            end
            if (done) begin
                done_count = done_count + 1;
                check_value("out_valid", 1, int'(out_valid));
                check_value("out_addr", ram_size - 1, int'(out_addr));
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycle_count) begin
                credit_return <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        check_value("idle", 1, int'(idle));
        check_value("done", 0, int'(done));
        run_load(2 + rand_below(13), 0, 1'b0, 1'b0);
        run_load(2 + rand_below(13), 0, 1'b1, 1'b0);
        run_load(14, 100, 1'b0, 1'b0);
        run_load(2, -100, 1'b0, 1'b0);
        run_load(2 + rand_below(13), 0, 1'b0, 1'b1);
        run_load(2 + rand_below(13), 0, 1'b0, 1'b0);
        if (errors == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "errors found at the end of the run");
        end
    end

endmodule

// ==== sim/wtb_loader_properties.sv ====
`include "wtb_config.svh"

module wtb_loader_properties (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic credit_return,
    input logic idle,
    input logic done
);

    localparam logic [3:0] max_outstanding = `WTB_CREDITS;

    // Words on the port whose credit has not come back yet
    logic [3:0] outstanding;
    logic       rst_q;

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            outstanding <= '0;
        end else begin
            case ({out_valid, credit_return})
                2'b10: outstanding <= outstanding + 4'd1;
                2'b01: outstanding <= outstanding - 4'd1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    credit_available: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (outstanding < max_outstanding))
        else $error("out_valid issued with no credit left");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held for two cycles");

    idle_not_done: assert property (@(posedge clk) disable iff (rst)
        !(idle && done))
        else $error("idle and done high together");

    quiet_in_reset: assert property (@(posedge clk)
        (rst && rst_q) |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

// ==== sim/wtb_clk_gen.sv ====
module wtb_clk_gen (
    output logic clk
);

    localparam int half_period = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// ==== rtl/wtb_loader_top.sv ====
`include "wtb_config.svh"

module wtb_loader_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wtb_load,
    input  logic                   key_we,
    input  logic [`WTB_KEY_AW-1:0] key_addr,
    input  logic [`WTB_POS_W-1:0]  key_pos,
    input  logic [`WTB_DATA_W-1:0] key_val,
    input  logic                   credit_return,
    output logic                   out_valid,
    output logic [`WTB_ADDR_W-1:0] out_addr,
    output logic [`WTB_DATA_W-1:0] out_data,
    output logic                   idle,
    output logic                   done
);

    wtb_ctrl_if ctrl_bus ();
    wtb_seg_if  seg_bus ();

    logic [`WTB_ADDR_W-1:0] fill_addr;
    logic [`WTB_POS_W-1:0]  seg_end_pos;
    logic                   can_send;
    logic                   word_valid;
    logic [`WTB_ADDR_W-1:0] word_addr;
    logic [`WTB_DATA_W-1:0] word_data;

    wtb_loader_fsm fsm0 (
        .clk(clk), .rst(rst), .wtb_load(wtb_load), .can_send(can_send),
        .fill_addr(fill_addr), .seg_end_pos(seg_end_pos), .ctrl(ctrl_bus.ctrl),
        .idle(idle), .done(done)
    );

    wtb_key_fetch key0 (
        .clk(clk), .rst(rst), .key_we(key_we), .key_addr(key_addr), .key_pos(key_pos),
        .key_val(key_val), .ctrl(ctrl_bus.dp), .seg(seg_bus.src), .seg_end_pos(seg_end_pos)
    );

    wtb_interp interp0 (
        .clk(clk), .rst(rst), .ctrl(ctrl_bus.dp), .seg(seg_bus.dst), .fill_addr(fill_addr),
        .word_valid(word_valid), .word_addr(word_addr), .word_data(word_data)
    );

    wtb_credit_out out0 (
        .clk(clk), .rst(rst), .word_valid(word_valid), .word_addr(word_addr),
        .word_data(word_data), .credit_return(credit_return), .can_send(can_send),
        .out_valid(out_valid), .out_addr(out_addr), .out_data(out_data)
    );

endmodule

// ==== rtl/wtb_credit_out.sv ====
`include "wtb_config.svh"

module wtb_credit_out (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   word_valid,
    input  logic [`WTB_ADDR_W-1:0] word_addr,
    input  logic [`WTB_DATA_W-1:0] word_data,
    input  logic                   credit_return,
    output logic                   can_send,
    output logic                   out_valid,
    output logic [`WTB_ADDR_W-1:0] out_addr,
    output logic [`WTB_DATA_W-1:0] out_data
);

    logic [`WTB_CREDIT_W-1:0] credits;

    // A word already in the output register holds one of the credits
    assign can_send = (credits > {{(`WTB_CREDIT_W - 1){1'b0}}, out_valid});

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            credits   <= `WTB_CREDIT_W'(`WTB_CREDITS);
        end else begin
            out_valid <= word_valid;
            case ({out_valid, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            out_addr <= word_addr;
            out_data <= word_data;
        end
    end

endmodule

// ==== rtl/wtb_interp.sv ====
`include "wtb_config.svh"

module wtb_interp (
    input  logic                   clk,
    input  logic                   rst,
    wtb_ctrl_if.dp                 ctrl,
    wtb_seg_if.dst                 seg,
    output logic [`WTB_ADDR_W-1:0] fill_addr,
    output logic                   word_valid,
    output logic [`WTB_ADDR_W-1:0] word_addr,
    output logic [`WTB_DATA_W-1:0] word_data
);

    localparam int prod_w = `WTB_DATA_W + `WTB_POS_W + 2;
    localparam int max_word = (1 << `WTB_DATA_W) - 1;

    logic signed [`WTB_DATA_W:0] dv;
    logic signed [`WTB_POS_W:0]  da;
    logic signed [`WTB_POS_W:0]  span;
    logic signed [prod_w-1:0]    prod;
    logic signed [prod_w-1:0]    quot;
    logic signed [prod_w:0]      sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_addr <= '0;
        end else if (ctrl.load_r) begin
            fill_addr <= seg.key_l.pos[`WTB_ADDR_W-1:0];
        end else if (ctrl.fill_step) begin
            fill_addr <= fill_addr + 1'b1;
        end
    end

    // Signed operands so the divide truncates toward zero
    always_comb begin
        dv   = $signed({1'b0, seg.key_r.val}) - $signed({1'b0, seg.key_l.val});
        da   = $signed({1'b0, {(`WTB_POS_W - `WTB_ADDR_W){1'b0}}, fill_addr})
             - $signed({1'b0, seg.key_l.pos});
        span = $signed({1'b0, seg.key_r.pos}) - $signed({1'b0, seg.key_l.pos});
        prod = dv * da;
        quot = prod / span;
        sum  = $signed({1'b0, seg.key_l.val}) + quot + $signed(seg.offset);
    end

    always_comb begin
        if (sum < 0) begin
            word_data = '0;
        end else if (sum > max_word) begin
            word_data = '1;
        end else begin
            word_data = sum[`WTB_DATA_W-1:0];
        end
    end

    assign word_valid = ctrl.fill_step;
    assign word_addr  = fill_addr;

endmodule

// ==== rtl/wtb_key_fetch.sv ====
`include "wtb_config.svh"

module wtb_key_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key_we,
    input  logic [`WTB_KEY_AW-1:0] key_addr,
    input  logic [`WTB_POS_W-1:0]  key_pos,
    input  logic [`WTB_DATA_W-1:0] key_val,
    wtb_ctrl_if.dp                 ctrl,
    wtb_seg_if.src                 seg,
    output logic [`WTB_POS_W-1:0]  seg_end_pos
);

    wtb_pkg::wtb_key_t key_mem [0:`WTB_KEY_DEPTH-1];
    wtb_pkg::wtb_key_t rd_data;
    logic [`WTB_KEY_AW-1:0] key_ptr;
    logic [`WTB_KEY_AW-1:0] rd_addr;
    logic sel_r;

    // While idle the read port keeps entry 0 ready for the offset load
    assign rd_addr = ctrl.busy ? key_ptr + {{(`WTB_KEY_AW - 1){1'b0}}, sel_r} : '0;

    always_ff @(posedge clk) begin
        if (key_we && !ctrl.busy) begin
            key_mem[key_addr] <= {key_pos, key_val};
        end
        if (ctrl.read_key || !ctrl.busy) begin
            rd_data <= key_mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_ptr <= '0;
            sel_r   <= 1'b0;
        end else if (ctrl.load_offset) begin
            key_ptr <= `WTB_KEY_AW'(1);
            sel_r   <= 1'b0;
        end else if (ctrl.load_l) begin
            sel_r <= 1'b1;
        end else if (ctrl.load_r) begin
            key_ptr <= key_ptr + 1'b1;
            sel_r   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_offset) begin
            seg.offset <= $signed(rd_data.val);
        end
        if (ctrl.load_l) begin
            seg.key_l <= rd_data;
        end
        if (ctrl.load_r) begin
            seg.key_r <= rd_data;
        end
    end

    assign seg_end_pos = seg.key_r.pos;

endmodule

// ==== rtl/wtb_loader_fsm.sv ====
`include "wtb_config.svh"

module wtb_loader_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wtb_load,
    input  logic                   can_send,
    input  logic [`WTB_ADDR_W-1:0] fill_addr,
    input  logic [`WTB_POS_W-1:0]  seg_end_pos,
    wtb_ctrl_if.ctrl               ctrl,
    output logic                   idle,
    output logic                   done
);

    localparam int last_addr = `WTB_RAM_SIZE - 1;

    wtb_pkg::wtb_state_e state;
    wtb_pkg::wtb_state_e next_state;
    logic [`WTB_POS_W-1:0] fill_pos;

    assign fill_pos = {{(`WTB_POS_W - `WTB_ADDR_W){1'b0}}, fill_addr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wtb_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state       = state;
        ctrl.load_offset = 1'b0;
        ctrl.read_key    = 1'b0;
        ctrl.load_l      = 1'b0;
        ctrl.load_r      = 1'b0;
        ctrl.fill_step   = 1'b0;
        ctrl.busy        = (state != wtb_pkg::idle);
        idle             = 1'b0;
        done             = 1'b0;

        case (state)
            wtb_pkg::idle: begin
                idle = 1'b1;
                if (wtb_load) begin
                    next_state = wtb_pkg::load_offset;
                end
            end
            wtb_pkg::load_offset: begin
                ctrl.load_offset = 1'b1;
                next_state       = wtb_pkg::read_key_l;
            end
            wtb_pkg::read_key_l: begin
                ctrl.read_key = 1'b1;
                next_state    = wtb_pkg::load_key_l;
            end
            wtb_pkg::load_key_l: begin
                ctrl.load_l = 1'b1;
                next_state  = wtb_pkg::read_key_r;
            end
            wtb_pkg::read_key_r: begin
                ctrl.read_key = 1'b1;
                next_state    = wtb_pkg::load_key_r;
            end
            wtb_pkg::load_key_r: begin
                ctrl.load_r = 1'b1;
                next_state  = wtb_pkg::fill;
            end
            wtb_pkg::fill: begin
                // The right key position itself is written by the next segment
                if (int'(fill_addr) == last_addr) begin
                    if (can_send) begin
                        ctrl.fill_step = 1'b1;
                        next_state     = wtb_pkg::done;
                    end
                end else if (fill_pos == seg_end_pos) begin
                    next_state = wtb_pkg::read_key_l;
                end else if (can_send) begin
                    ctrl.fill_step = 1'b1;
                end
            end
            wtb_pkg::done: begin
                done       = 1'b1;
                next_state = wtb_pkg::idle;
            end
            default: begin
                next_state = wtb_pkg::idle;
            end
        endcase
    end

endmodule

// ==== rtl/wtb_ifs.sv ====
`include "wtb_config.svh"

// One-cycle strobes from the loader FSM to the datapath
interface wtb_ctrl_if;
    logic load_offset;
    logic read_key;
    logic load_l;
    logic load_r;
    logic fill_step;
    logic busy;

    modport ctrl (
        output load_offset, read_key, load_l, load_r, fill_step, busy
    );
    modport dp (
        input load_offset, read_key, load_l, load_r, fill_step, busy
    );
endinterface

// Offset and the two keys that bound the current segment
interface wtb_seg_if;
    logic signed [`WTB_DATA_W-1:0] offset;
    wtb_pkg::wtb_key_t             key_l;
    wtb_pkg::wtb_key_t             key_r;

    modport src (
        output offset, key_l, key_r
    );
    modport dst (
        input offset, key_l, key_r
    );
endinterface

// ==== rtl/wtb_pkg.sv ====
`include "wtb_config.svh"

package wtb_pkg;

    // Sequence of the loader FSM, in the order the states are visited
    typedef enum logic [2:0] {
        idle        = 3'd0,
        load_offset = 3'd1,
        read_key_l  = 3'd2,
        load_key_l  = 3'd3,
        read_key_r  = 3'd4,
        load_key_r  = 3'd5,
        fill        = 3'd6,
        done        = 3'd7
    } wtb_state_e;

    // One key point; entry 0 of the store uses val as the signed offset
    typedef struct packed {
        logic [`WTB_POS_W-1:0]  pos;
        logic [`WTB_DATA_W-1:0] val;
    } wtb_key_t;

endpackage

// ==== rtl/wtb_config.svh ====
`ifndef WTB_CONFIG_SVH
`define WTB_CONFIG_SVH

// Wavetable geometry
`define WTB_RAM_SIZE 61
`define WTB_ADDR_W 6
`define WTB_DATA_W 8
`define WTB_POS_W 8

// Key store and output stream
`define WTB_KEY_DEPTH 16
`define WTB_KEY_AW 4
`define WTB_CREDITS 4
`define WTB_CREDIT_W 3
`endif
